//--- design/memory_map_pkg.sv
package memory_map_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [22:0] mem_addr_t;

    // One write into system memory
    typedef struct packed {
        logic      strobe;
        mem_addr_t addr;
        byte_t     data;
        logic      internal;
    } mem_wr_t;

    // Inclusive processor address range
    typedef struct packed {
        cpu_addr_t lo;
        cpu_addr_t hi;
    } addr_range_t;

    // ========================================
    // Region bases in system memory
    // ========================================
    localparam mem_addr_t TAP_MEM_START    = 23'h20000;
    localparam mem_addr_t DRIVE_ROM_BASE   = 23'h00000;
    localparam mem_addr_t KERNAL_PAL_BASE  = 23'h0E000;
    localparam mem_addr_t KERNAL_NTSC_BASE = 23'h1E000;
    localparam mem_addr_t BASIC_ROM_BASE   = 23'h0C000;
    localparam mem_addr_t CHAR_ROM_BASE    = 23'h08000;

    // ========================================
    // Processor side addresses
    // ========================================
    localparam cpu_addr_t PRG_CART_ADDR  = 16'hA000;
    localparam cpu_addr_t PRG_LOAD_LIMIT = 16'hBFFF;

    // BASIC start and end pointers, low byte first
    localparam cpu_addr_t [0:7] BASIC_PTR_ADDRS = {
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

    // Processor ranges backed by on-chip RAM
    localparam addr_range_t [0:2] PRG_INTERNAL_RANGES = {
        {16'h0000, 16'h03FF},
        {16'h1000, 16'h1FFF},
        {16'h9400, 16'h97FF}
    };

endpackage

//--- design/loader_pkg.sv
package loader_pkg;

    typedef logic [24:0] dl_addr_t;
    typedef logic [4:0]  inject_step_t;

    // Host download bus, one strobe per byte
    typedef struct packed {
        logic                  active;
        logic                  strobe;
        logic [7:0]            index;
        dl_addr_t              addr;
        memory_map_pkg::byte_t data;
    } dl_bus_t;

    typedef enum logic [1:0] {
        DL_NONE,
        DL_ROM,
        DL_PRG,
        DL_TAP
    } dl_kind_t;

    // ========================================
    // File index codes from the host
    // ========================================
    localparam logic [7:0] IDX_ROM   = 8'h00;
    localparam logic [7:0] IDX_PRG_A = 8'h01;
    localparam logic [7:0] IDX_PRG_B = 8'h41;
    localparam logic [7:0] IDX_TAP   = 8'h81;

    // Version byte in the tape file header
    localparam dl_addr_t TAP_VERSION_OFFSET = 25'h0000C;

    localparam inject_step_t INJECT_LAST_STEP = 5'd31;

endpackage

//--- design/download_decoder.sv
`timescale 1ns/1ps

module download_decoder (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  loader_pkg::dl_bus_t  dl_i,
    output loader_pkg::dl_kind_t kind_o,
    output logic                 prg_done_o
);
    import loader_pkg::*;

    logic prg_active_q;

    // Megacart and unknown indices fall through to DL_NONE
    always_comb begin
        kind_o = DL_NONE;
        if (dl_i.active) begin
            case (dl_i.index)
                IDX_ROM:              kind_o = DL_ROM;
                IDX_PRG_A, IDX_PRG_B: kind_o = DL_PRG;
                IDX_TAP:              kind_o = DL_TAP;
                default:              kind_o = DL_NONE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_active_q <= 1'b0;
        end else begin
            prg_active_q <= (kind_o == DL_PRG);
        end
    end

    // Falling edge of the PRG download
    assign prg_done_o = prg_active_q && (kind_o != DL_PRG);

endmodule

//--- design/rom_mapper.sv
`timescale 1ns/1ps

module rom_mapper (
    input  logic                    clk_sys,
    input  logic                    reset,
    input  loader_pkg::dl_bus_t     dl_i,
    input  loader_pkg::dl_kind_t    kind_i,
    output memory_map_pkg::mem_wr_t req_o
);
    import memory_map_pkg::*;
    import loader_pkg::*;

    mem_addr_t rom_addr;
    logic      rom_hit;
    logic      rom_internal;

    // Region select from offset bits 15..13
    always_comb begin
        rom_addr     = '0;
        rom_hit      = (dl_i.addr[24:16] == '0);
        rom_internal = 1'b0;
        case (dl_i.addr[15:13])
            3'b000, 3'b001: rom_addr = DRIVE_ROM_BASE + mem_addr_t'(dl_i.addr[13:0]);
            3'b010:         rom_addr = KERNAL_PAL_BASE + mem_addr_t'(dl_i.addr[12:0]);
            3'b011:         rom_addr = KERNAL_NTSC_BASE + mem_addr_t'(dl_i.addr[12:0]);
            3'b100:         rom_addr = BASIC_ROM_BASE + mem_addr_t'(dl_i.addr[12:0]);
            3'b101: begin
                // Character set lives on chip
                rom_addr     = CHAR_ROM_BASE + mem_addr_t'(dl_i.addr[11:0]);
                rom_internal = 1'b1;
            end
            default:        rom_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            req_o.strobe <= 1'b0;
        end else begin
            req_o.strobe <= dl_i.strobe && (kind_i == DL_ROM) && rom_hit;
        end
        req_o.addr     <= rom_addr;
        req_o.data     <= dl_i.data;
        req_o.internal <= rom_internal;
    end

endmodule

//--- design/prg_loader.sv
`timescale 1ns/1ps

module prg_loader (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  loader_pkg::dl_bus_t       dl_i,
    input  loader_pkg::dl_kind_t      kind_i,
    input  logic                      prg_no_header_i,
    output memory_map_pkg::mem_wr_t   req_o,
    output memory_map_pkg::cpu_addr_t end_addr_o,
    output logic                      auto_reset_o
);
    import memory_map_pkg::*;
    import loader_pkg::*;

    cpu_addr_t load_addr;
    cpu_addr_t wr_addr;
    logic      prg_byte;
    logic      first_byte;
    logic      header_byte;
    logic      wr_en;

    assign prg_byte   = dl_i.strobe && (kind_i == DL_PRG);
    assign first_byte = (dl_i.addr == '0);

    // Offsets 0 and 1 carry the load address when a header is present
    assign header_byte = !prg_no_header_i && (dl_i.addr < dl_addr_t'(2));
    assign wr_en       = prg_byte && !header_byte;

    // Headerless files start at the cartridge slot
    assign wr_addr = (prg_no_header_i && first_byte) ? PRG_CART_ADDR : load_addr;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            req_o.strobe <= 1'b0;
            auto_reset_o <= 1'b0;
            end_addr_o   <= '0;
        end else begin
            req_o.strobe <= wr_en;
            // A new file drops the flag of the previous load
            if (prg_byte && first_byte) begin
                auto_reset_o <= 1'b0;
            end
            if (wr_en && (wr_addr == PRG_CART_ADDR)) begin
                auto_reset_o <= 1'b1;
            end
            if (wr_en) begin
                end_addr_o <= wr_addr;
            end
        end

        if (prg_byte && header_byte) begin
            if (dl_i.addr[0]) begin
                load_addr[15:8] <= dl_i.data;
            end else begin
                load_addr[7:0] <= dl_i.data;
            end
        end else if (wr_en) begin
            // Hold at the limit so ROM above is never touched
            load_addr <= (wr_addr < PRG_LOAD_LIMIT) ? wr_addr + 16'd1 : wr_addr;
        end

        req_o.addr     <= mem_addr_t'(wr_addr);
        req_o.data     <= dl_i.data;
        req_o.internal <= 1'b0;
    end

endmodule

//--- design/pointer_injector.sv
`timescale 1ns/1ps

module pointer_injector (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      prg_done_i,
    input  memory_map_pkg::cpu_addr_t end_addr_i,
    input  logic                      auto_reset_i,
    output memory_map_pkg::mem_wr_t   req_o,
    output logic                      busy_o,
    output logic                      reset_req_o
);
    import memory_map_pkg::*;
    import loader_pkg::*;

    inject_step_t step;
    logic [2:0]   ptr_sel;

    // Steps 1,3,..,15 map to pointer slots 0..7
    assign ptr_sel = step[3:1];
    assign busy_o  = (step != '0);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            step         <= '0;
            req_o.strobe <= 1'b0;
            reset_req_o  <= 1'b0;
        end else begin
            if (prg_done_i) begin
                step <= inject_step_t'(1);
            end else if (step == INJECT_LAST_STEP) begin
                step <= '0;
            end else if (busy_o) begin
                step <= step + 5'd1;
            end
            req_o.strobe <= busy_o && step[0] && !step[4];
            reset_req_o  <= (step == INJECT_LAST_STEP) && auto_reset_i;
        end

        req_o.addr     <= mem_addr_t'(BASIC_PTR_ADDRS[ptr_sel]);
        // Low byte on slots 0,2,4,6 and high byte on the others
        req_o.data     <= step[1] ? end_addr_i[15:8] : end_addr_i[7:0];
        req_o.internal <= 1'b1;
    end

endmodule

//--- design/tap_loader.sv
`timescale 1ns/1ps

module tap_loader (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  loader_pkg::dl_bus_t       dl_i,
    input  loader_pkg::dl_kind_t      kind_i,
    output memory_map_pkg::mem_wr_t   req_o,
    output logic                      tap_version_o,
    output memory_map_pkg::mem_addr_t tap_end_o
);
    import memory_map_pkg::*;
    import loader_pkg::*;

    mem_addr_t tap_addr;
    logic      tap_wr;

    assign tap_wr   = dl_i.strobe && (kind_i == DL_TAP);
    assign tap_addr = TAP_MEM_START + mem_addr_t'(dl_i.addr);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            req_o.strobe  <= 1'b0;
            tap_version_o <= 1'b0;
            tap_end_o     <= TAP_MEM_START;
        end else begin
            req_o.strobe <= tap_wr;
            if (tap_wr) begin
                tap_end_o <= tap_addr;
            end
            if (tap_wr && (dl_i.addr == TAP_VERSION_OFFSET)) begin
                tap_version_o <= dl_i.data[0];
            end
        end
        req_o.addr     <= tap_addr;
        req_o.data     <= dl_i.data;
        req_o.internal <= 1'b0;
    end

endmodule

//--- design/mem_write_mux.sv
`timescale 1ns/1ps

module mem_write_mux (
    input  loader_pkg::dl_kind_t    kind_i,
    input  logic                    inject_busy_i,
    input  memory_map_pkg::mem_wr_t rom_req_i,
    input  memory_map_pkg::mem_wr_t prg_req_i,
    input  memory_map_pkg::mem_wr_t tap_req_i,
    input  memory_map_pkg::mem_wr_t inj_req_i,
    output memory_map_pkg::mem_wr_t mem_wr_o
);
    import memory_map_pkg::*;
    import loader_pkg::*;

    mem_wr_t prg_req;
    logic    prg_in_range;

    // PRG bytes landing in on-chip RAM
    always_comb begin
        prg_in_range = 1'b0;
        for (int i = 0; i < $size(PRG_INTERNAL_RANGES); i++) begin
            if (prg_req_i.addr[15:0] >= PRG_INTERNAL_RANGES[i].lo &&
                prg_req_i.addr[15:0] <= PRG_INTERNAL_RANGES[i].hi) begin
                prg_in_range = 1'b1;
            end
        end
        prg_req          = prg_req_i;
        prg_req.internal = prg_in_range;
    end

    always_comb begin
        if (inject_busy_i) begin
            mem_wr_o = inj_req_i;
        end else begin
            case (kind_i)
                DL_ROM: mem_wr_o = rom_req_i;
                DL_PRG: mem_wr_o = prg_req;
                DL_TAP: mem_wr_o = tap_req_i;
                default: begin
                    // Last byte of a file still in flight after active drops
                    if (rom_req_i.strobe) begin
                        mem_wr_o = rom_req_i;
                    end else if (prg_req.strobe) begin
                        mem_wr_o = prg_req;
                    end else if (tap_req_i.strobe) begin
                        mem_wr_o = tap_req_i;
                    end else begin
                        mem_wr_o = '0;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/image_loader.sv
`timescale 1ns/1ps

module image_loader (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  loader_pkg::dl_bus_t       dl_i,
    input  logic                      prg_no_header_i,
    output memory_map_pkg::mem_wr_t   mem_wr_o,
    output logic                      tap_version_o,
    output memory_map_pkg::mem_addr_t tap_end_o,
    output logic                      reset_req_o
);
    import memory_map_pkg::*;
    import loader_pkg::*;

    dl_kind_t  kind;
    logic      prg_done;
    cpu_addr_t prg_end_addr;
    logic      auto_reset;
    logic      inject_busy;
    mem_wr_t   rom_req;
    mem_wr_t   prg_req;
    mem_wr_t   tap_req;
    mem_wr_t   inj_req;

    // ========================================
    // Download classification
    // ========================================
    download_decoder i_download_decoder (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .dl_i       (dl_i),
        .kind_o     (kind),
        .prg_done_o (prg_done)
    );

    // ========================================
    // Write sources
    // ========================================
    rom_mapper i_rom_mapper (
        .clk_sys (clk_sys),
        .reset   (reset),
        .dl_i    (dl_i),
        .kind_i  (kind),
        .req_o   (rom_req)
    );

    prg_loader i_prg_loader (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl_i            (dl_i),
        .kind_i          (kind),
        .prg_no_header_i (prg_no_header_i),
        .req_o           (prg_req),
        .end_addr_o      (prg_end_addr),
        .auto_reset_o    (auto_reset)
    );

    pointer_injector i_pointer_injector (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .prg_done_i   (prg_done),
        .end_addr_i   (prg_end_addr),
        .auto_reset_i (auto_reset),
        .req_o        (inj_req),
        .busy_o       (inject_busy),
        .reset_req_o  (reset_req_o)
    );

    tap_loader i_tap_loader (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_i          (dl_i),
        .kind_i        (kind),
        .req_o         (tap_req),
        .tap_version_o (tap_version_o),
        .tap_end_o     (tap_end_o)
    );

    // ========================================
    // Output selection
    // ========================================
    mem_write_mux i_mem_write_mux (
        .kind_i        (kind),
        .inject_busy_i (inject_busy),
        .rom_req_i     (rom_req),
        .prg_req_i     (prg_req),
        .tap_req_i     (tap_req),
        .inj_req_i     (inj_req),
        .mem_wr_o      (mem_wr_o)
    );

endmodule

//--- verif/tb_image_loader.sv
`timescale 1ns/1ps

module tb_image_loader;
    import memory_map_pkg::*;
    import loader_pkg::*;

    // Headerless PRG runs 16 bytes past the cartridge limit
    localparam int CART_FILE_LEN = 'h2010;
    // Headerless PRG makes up most of the 8.5k cycles of traffic
    localparam int CYCLE_LIMIT   = 20000;
    localparam int SETTLE_CYCLES = int'(INJECT_LAST_STEP) + 4;
    // Queue entries for writes with no fixed cycle
    localparam int DUE_ANY        = -1;
    localparam int DUE_AFTER_PREV = -2;

    logic      clk_sys;
    logic      reset;
    dl_bus_t   dl;
    logic      prg_no_header;
    mem_wr_t   mem_wr;
    logic      tap_version;
    mem_addr_t tap_end;
    logic      reset_req;

    integer    seed;
    int        cycle_count;
    int        reset_pulses;
    int        last_wr_cycle;
    mem_wr_t   exp_q[$];
    int        due_q[$];
    dl_kind_t  cur_kind;
    cpu_addr_t cur_header;
    mem_addr_t last_wr_addr;

    image_loader i_image_loader (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl_i            (dl),
        .prg_no_header_i (prg_no_header),
        .mem_wr_o        (mem_wr),
        .tap_version_o   (tap_version),
        .tap_end_o       (tap_end),
        .reset_req_o     (reset_req)
    );

    always #50 clk_sys = ~clk_sys;

    // ========================================
    // Reference model
    // ========================================
    function automatic dl_kind_t file_kind(logic [7:0] index);
        case (index)
            8'h00:        return DL_ROM;
            8'h01, 8'h41: return DL_PRG;
            8'h81:        return DL_TAP;
            default:      return DL_NONE;
        endcase
    endfunction

    function automatic mem_wr_t expected_write(dl_kind_t kind, logic no_header,
                                               cpu_addr_t header, dl_addr_t offset,
                                               byte_t data);
        mem_wr_t wr;
        int      target;
        wr = '0;
        wr.data = data;
        case (kind)
            DL_ROM: begin
                wr.strobe = (offset < 25'h0C000);
                if (offset < 25'h04000) begin
                    wr.addr = DRIVE_ROM_BASE + mem_addr_t'(offset);
                end else if (offset < 25'h06000) begin
                    wr.addr = KERNAL_PAL_BASE + mem_addr_t'(offset - 25'h04000);
                end else if (offset < 25'h08000) begin
                    wr.addr = KERNAL_NTSC_BASE + mem_addr_t'(offset - 25'h06000);
                end else if (offset < 25'h0A000) begin
                    wr.addr = BASIC_ROM_BASE + mem_addr_t'(offset - 25'h08000);
                end else begin
                    // Character ROM aliases on the low 12 bits
                    wr.addr = CHAR_ROM_BASE + mem_addr_t'(offset[11:0]);
                    wr.internal = 1'b1;
                end
            end
            DL_PRG: begin
                if (!no_header && offset < dl_addr_t'(2)) begin
                    wr.strobe = 1'b0;
                end else begin
                    if (no_header) begin
                        target = int'(PRG_CART_ADDR) + int'(offset);
                    end else begin
                        target = int'(header) + int'(offset) - 2;
                    end
                    if (target > int'(PRG_LOAD_LIMIT)) begin
                        target = int'(PRG_LOAD_LIMIT);
                    end
                    wr.strobe = 1'b1;
                    wr.addr = mem_addr_t'(target);
                    wr.internal = (target <= 'h03FF) ||
                                  (target >= 'h1000 && target <= 'h1FFF) ||
                                  (target >= 'h9400 && target <= 'h97FF);
                end
            end
            DL_TAP: begin
                wr.strobe = 1'b1;
                wr.addr = TAP_MEM_START + mem_addr_t'(offset);
            end
            default: wr.strobe = 1'b0;
        endcase
        return wr;
    endfunction

    // ========================================
    // Checking
    // ========================================
    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, want);
            $display("Errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Run aborted");
    endtask

    // Every mem_wr_o strobe against the head of the queue
    always @(posedge clk_sys) begin
        mem_wr_t want;
        int      due;
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run("Timeout, the tests did not finish within the cycle limit");
        end else if (!reset) begin
            if (reset_req === 1'b1) begin
                reset_pulses = reset_pulses + 1;
            end
            if (mem_wr.strobe === 1'b1 && exp_q.size() == 0) begin
                abort_run("A write appeared on mem_wr_o while no write was expected");
            end else if (mem_wr.strobe === 1'b1) begin
                want = exp_q.pop_front();
                due = due_q.pop_front();
                check_value("mem_wr_o.addr", 32'(mem_wr.addr), 32'(want.addr));
                check_value("mem_wr_o.data", 32'(mem_wr.data), 32'(want.data));
                check_value("mem_wr_o.internal", 32'(mem_wr.internal), 32'(want.internal));
                if (due >= 0) begin
                    check_value("mem_wr_o cycle", 32'(cycle_count), 32'(due));
                end else if (due == DUE_AFTER_PREV) begin
                    // Pointer writes come on alternate cycles
                    check_value("mem_wr_o cycle", 32'(cycle_count), 32'(last_wr_cycle + 2));
                end
                last_wr_cycle = cycle_count;
            end else if (due_q.size() != 0 && due_q[0] >= 0 && due_q[0] <= cycle_count) begin
                abort_run("An expected write did not appear on mem_wr_o in time");
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    task automatic start_file(logic [7:0] index, logic no_header, cpu_addr_t header);
        cur_kind = file_kind(index);
        cur_header = header;
        prg_no_header = no_header;
        dl.index = index;
        dl.active = 1'b1;
    endtask

    task automatic send_byte(dl_addr_t offset, byte_t data);
        mem_wr_t want;
        dl.strobe = 1'b1;
        dl.addr = offset;
        dl.data = data;
        want = expected_write(cur_kind, prg_no_header, cur_header, offset, data);
        if (want.strobe) begin
            exp_q.push_back(want);
            due_q.push_back(cycle_count + 2);
            last_wr_addr = want.addr;
        end
        @(negedge clk_sys);
        dl.strobe = 1'b0;
    endtask

    // Drop active, expect the BASIC pointers after a PRG, wait for the queue
    task automatic finish_file();
        mem_wr_t ptr;
        int      slot;
        dl.active = 1'b0;
        dl.strobe = 1'b0;
        if (cur_kind == DL_PRG) begin
            for (slot = 0; slot < 8; slot++) begin
                ptr = '0;
                ptr.strobe = 1'b1;
                ptr.addr = mem_addr_t'(BASIC_PTR_ADDRS[slot]);
                ptr.data = slot[0] ? last_wr_addr[15:8] : last_wr_addr[7:0];
                ptr.internal = 1'b1;
                exp_q.push_back(ptr);
                due_q.push_back((slot == 0) ? DUE_ANY : DUE_AFTER_PREV);
            end
        end
        while (exp_q.size() != 0) begin
            @(negedge clk_sys);
        end
        repeat (SETTLE_CYCLES) @(negedge clk_sys);
    endtask

    task automatic rom_image_test();
        int i;
        int rnd;
        start_file(IDX_ROM, 1'b0, '0);
        // One byte per 1 KiB block, so every region is hit
        for (i = 0; i < 64; i++) begin
            rnd = $random(seed);
            send_byte(dl_addr_t'({i[5:0], rnd[17:8]}), rnd[7:0]);
        end
        finish_file();
    endtask

    task automatic prg_header_test();
        int n;
        int rnd;
        int pulses_before;
        pulses_before = reset_pulses;
        start_file(IDX_PRG_A, 1'b0, 16'h1000);
        send_byte(dl_addr_t'(0), 8'h00);
        send_byte(dl_addr_t'(1), 8'h10);
        for (n = 2; n < 32; n++) begin
            rnd = $random(seed);
            send_byte(dl_addr_t'(n), rnd[7:0]);
        end
        finish_file();
        check_value("reset_req_o pulses", 32'(reset_pulses - pulses_before), 32'h0);
    endtask

    task automatic prg_cart_test();
        int n;
        int rnd;
        int pulses_before;
        pulses_before = reset_pulses;
        start_file(IDX_PRG_B, 1'b1, '0);
        for (n = 0; n < CART_FILE_LEN; n++) begin
            rnd = $random(seed);
            send_byte(dl_addr_t'(n), rnd[7:0]);
        end
        finish_file();
        check_value("reset_req_o pulses", 32'(reset_pulses - pulses_before), 32'h1);
    endtask

    task automatic tape_image_test();
        int    n;
        int    rnd;
        byte_t data;
        logic  version;
        version = 1'b0;
        start_file(IDX_TAP, 1'b0, '0);
        for (n = 0; n < 32; n++) begin
            rnd = $random(seed);
            // Only the version byte carries a set bit 0
            data = {rnd[7:1], dl_addr_t'(n) == TAP_VERSION_OFFSET};
            if (dl_addr_t'(n) == TAP_VERSION_OFFSET) begin
                version = data[0];
            end
            send_byte(dl_addr_t'(n), data);
        end
        finish_file();
        check_value("tap_version_o", 32'(tap_version), 32'(version));
        check_value("tap_end_o", 32'(tap_end), 32'(last_wr_addr));
    endtask

    task automatic unknown_index_test();
        int n;
        int rnd;
        int pulses_before;
        pulses_before = reset_pulses;
        start_file(8'h02, 1'b0, '0);
        for (n = 0; n < 16; n++) begin
            rnd = $random(seed);
            send_byte(dl_addr_t'(n), rnd[7:0]);
        end
        finish_file();
        check_value("reset_req_o pulses", 32'(reset_pulses - pulses_before), 32'h0);
    endtask

    initial begin
        seed = 32'hc531_2c97;
        clk_sys = 1'b0;
        reset = 1'b1;
        dl = '0;
        prg_no_header = 1'b0;
        cycle_count = 0;
        reset_pulses = 0;
        last_wr_cycle = 0;
        cur_kind = DL_NONE;
        cur_header = '0;
        last_wr_addr = '0;
        repeat (2) @(negedge clk_sys);
        reset = 1'b0;

        // Values right after reset
        check_value("mem_wr_o.strobe", 32'(mem_wr.strobe), 32'h0);
        check_value("reset_req_o", 32'(reset_req), 32'h0);
        check_value("tap_version_o", 32'(tap_version), 32'h0);
        check_value("tap_end_o", 32'(tap_end), 32'(TAP_MEM_START));

        rom_image_test();
        // Cartridge load first, so the header load sees the flag cleared
        prg_cart_test();
        prg_header_test();
        tape_image_test();
        unknown_index_test();

        $display("No errors");
        $finish;
    end

endmodule

//--- project.f
design/memory_map_pkg.sv
design/loader_pkg.sv
design/download_decoder.sv
design/rom_mapper.sv
design/prg_loader.sv
design/pointer_injector.sv
design/tap_loader.sv
design/mem_write_mux.sv
design/image_loader.sv
verif/tb_image_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the image loader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_image_loader -f project.f
./obj_dir/Vtb_image_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
